//--- Makefile
VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= cache_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- bench/cache_golden.txt
# op addr wdata expect, all hex, op 0 is a read and op 1 is a write
# expect is checked on reads only, writes carry 0000 there
0 0120 0000 0000
1 0240 1234 0000
0 0240 0000 1234
1 0380 00a0 0000
1 0382 00a1 0000
1 0384 00a2 0000
1 0386 00a3 0000
1 0388 00a4 0000
1 038a 00a5 0000
1 038c 00a6 0000
1 038e 00a7 0000
0 0380 0000 00a0
0 0382 0000 00a1
0 0384 0000 00a2
0 0386 0000 00a3
0 0388 0000 00a4
0 038a 0000 00a5
0 038c 0000 00a6
0 038e 0000 00a7
1 0500 5a5a 0000
0 0d00 0000 0000
0 0500 0000 5a5a
1 0d02 c3c3 0000
0 0502 0000 0000
0 0d02 0000 c3c3
1 1a30 7777 0000
0 0240 0000 1234
1 7ff6 beef 0000
0 1a30 0000 7777
0 7ff6 0000 beef
1 0246 4321 0000
0 0246 0000 4321
0 0240 0000 1234
1 ffe0 0f0f 0000
0 038e 0000 00a7
0 ffe0 0000 0f0f

//--- bench/cache_tb.sv
// Write-through cache testbench
`timescale 1ns/1ps

module cache_tb;
    import cache_pkg::*;

    localparam int timeout_cycles = 200;             // longest wait for stall to fall
    localparam int index_lo       = 1 + offset_width;  // lowest index bit of an address
    localparam int tag_lo         = addr_width - tag_width;  // lowest tag bit of an address

    logic                  clk;
    logic                  rst_n;
    logic                  cpu_req;
    cpu_op_t               cpu_op;
    logic [addr_width-1:0] cpu_addr;
    logic [data_width-1:0] cpu_wdata;
    logic [data_width-1:0] cpu_rdata;
    logic                  stall;

    logic [tag_width-1:0]  held_tag [num_sets];    // block each set holds after its last fill
    logic                  held_valid [num_sets];  // set has been filled since reset
    logic [data_width-1:0] shadow [logic [addr_width-1:0]];  // last golden word per address
    integer                seed;
    integer                fd;
    int                    accesses;

    cache_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .cpu_req   (cpu_req),
        .cpu_op    (cpu_op),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_rdata (cpu_rdata),
        .stall     (stall)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic check_rdata(input string name, input logic [data_width-1:0] expected,
                               input logic [data_width-1:0] actual);
        if (actual !== expected) begin
            $display("FAIL time=%0t signal=%s expected=%h actual=%h",
                     $time, name, expected, actual);
            abort_run("read data differs from the golden value");
        end
    endtask

    task automatic check_stall(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAIL time=%0t signal=%s expected=%b actual=%b",
                     $time, name, expected, actual);
            abort_run("stall does not follow the hit and miss pattern");
        end
    endtask

    // called 1 ns after a rising edge, returns at the same point of a later cycle
    task automatic idle_cycles(input int count);
        repeat (count) begin
            #1;
            check_stall("stall", 1'b0, stall);  // no request means no stall
            @(posedge clk);
            #1;
        end
    endtask

    task automatic run_access(input cpu_op_t op, input logic [addr_width-1:0] addr,
                              input logic [data_width-1:0] wdata,
                              input logic [data_width-1:0] expected);
        logic [index_width-1:0] idx;
        logic [tag_width-1:0]   tag;
        logic                   expect_miss;
        int                     waited;
        idx         = addr[index_lo +: index_width];
        tag         = addr[addr_width-1 -: tag_width];
        expect_miss = !held_valid[idx] || (held_tag[idx] != tag);  // direct mapped lookup
        cpu_req     = 1'b1;
        cpu_op      = op;
        cpu_addr    = addr;
        cpu_wdata   = wdata;
        #1;
        check_stall("stall", expect_miss, stall);  // a hit must not stall at all
        waited = 0;
        while (stall) begin
            @(posedge clk);
            #2;  // mid cycle, where stall is settled
            waited++;
            if (waited > timeout_cycles) begin
                abort_run("stall stayed high past the timeout, the block fill never finished");
            end
        end
        if (op == op_read) begin
            check_rdata("cpu_rdata", expected, cpu_rdata);  // valid in the completing cycle
        end
        @(posedge clk);  // the access completes at this edge
        #1;
        cpu_req         = 1'b0;
        held_valid[idx] = 1'b1;
        held_tag[idx]   = tag;
    endtask

    // each golden address is read again straight out of a refill, so every word offset
    // of a block has to come back from the pipelined memory responses
    task automatic refill_readback();
        logic [addr_width-1:0] alias_addr;
        foreach (shadow[a]) begin
            alias_addr         = a;
            alias_addr[tag_lo] = !a[tag_lo];  // same set, other block, evicts the first
            run_access(op_read, alias_addr, '0,
                       shadow.exists(alias_addr) ? shadow[alias_addr] : '0);
            run_access(op_read, a, '0, shadow[a]);
        end
    endtask

    initial begin
        string line;
        int    op_v;
        int    addr_v;
        int    wdata_v;
        int    exp_v;
        int    fields;
        int    gap;
        seed      = 53;
        rst_n     = 1'b0;
        cpu_req   = 1'b0;
        cpu_op    = op_read;
        cpu_addr  = '0;
        cpu_wdata = '0;
        accesses  = 0;
        for (int s = 0; s < num_sets; s++) begin
            held_valid[s] = 1'b0;  // reset clears every valid bit
            held_tag[s]   = '0;
        end
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        idle_cycles(6);  // quiet port after reset
        fd = $fopen("bench/cache_golden.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open bench/cache_golden.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            fields = $sscanf(line, "%h %h %h %h", op_v, addr_v, wdata_v, exp_v);
            if (fields == 4) begin  // comment and blank lines give no fields
                run_access(op_v[0] ? op_write : op_read, addr_v[addr_width-1:0],
                           wdata_v[data_width-1:0], exp_v[data_width-1:0]);
                // memory holds the written word after a write-through
                shadow[addr_v[addr_width-1:0]] = op_v[0] ? wdata_v[data_width-1:0]
                                                         : exp_v[data_width-1:0];
                gap = $unsigned($random(seed)) % 4;
                idle_cycles(gap);
                accesses++;
            end
        end
        $fclose(fd);
        if (accesses == 0) begin
            abort_run("the golden file held no accesses");
        end else begin
            refill_readback();
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

//--- cache_top.f
design/cache_pkg.sv
design/mem_bus_if.sv
design/cache_fill_fsm.sv
design/cache_tag_array.sv
design/cache_data_array.sv
design/mem_model.sv
design/cache_top.sv
bench/cache_tb.sv

//--- design/cache_data_array.sv
// Cache word storage
`timescale 1ns/1ps

module cache_data_array (
    input  logic                               clk,
    input  logic [cache_pkg::addr_width-1:0]   addr,
    input  logic                               fill_write,
    input  logic [cache_pkg::offset_width-1:0] fill_offset,
    input  logic [cache_pkg::data_width-1:0]   fill_data,
    input  logic                               cpu_write_hit,
    input  logic [cache_pkg::data_width-1:0]   cpu_wdata,
    output logic [cache_pkg::data_width-1:0]   rdata
);
    import cache_pkg::*;

    localparam int word_bits = index_width + offset_width;  // 10 bits for 1024 words

    logic [data_width-1:0]   words [num_sets * words_per_block];
    logic [index_width-1:0]  addr_index;
    logic [word_bits-1:0]    cpu_word;   // word picked by the processor address
    logic [word_bits-1:0]    fill_word;  // word picked by the fill offset in the same set

    assign addr_index = addr[1 + offset_width +: index_width];
    assign cpu_word   = addr[1 +: word_bits];  // byte bit dropped
    assign fill_word  = {addr_index, fill_offset};

    // fill and processor writes never coincide, a fill only runs while stalled
    always_ff @(posedge clk) begin
        if (fill_write) begin
            words[fill_word] <= fill_data;
        end else if (cpu_write_hit) begin
            words[cpu_word] <= cpu_wdata;  // keeps the cached copy equal to memory
        end
    end

    // read data is ready in the cycle the access completes
    assign rdata = words[cpu_word];

endmodule

//--- design/cache_fill_fsm.sv
// Cache miss and block fill controller
`timescale 1ns/1ps

module cache_fill_fsm (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             cpu_req,
    input  cache_pkg::cpu_op_t               cpu_op,
    input  logic [cache_pkg::addr_width-1:0] cpu_addr,
    input  logic [cache_pkg::data_width-1:0] cpu_wdata,
    input  logic                             hit,
    mem_bus_if.controller                    mem,
    output logic                             stall,
    output logic                             fill_write,
    output logic [cache_pkg::offset_width-1:0] fill_offset,
    output logic                             tag_write,
    output logic                             cpu_write_hit
);
    import cache_pkg::*;

    localparam int blk_width = tag_width + index_width;  // tag and index of a block

    fill_state_t                 state;
    logic [blk_width-1:0]        block_addr;  // block of the access that missed
    logic [offset_width-1:0]     issue_cnt;   // word offset of the next read to send
    logic [offset_width-1:0]     resp_cnt;    // word offset of the next returning word
    logic                        miss;
    logic                        last_issue;
    logic                        last_resp;

    assign miss       = cpu_req && !hit;  // only meaningful while idle
    assign last_issue = (issue_cnt == offset_width'(words_per_block - 1));
    assign last_resp  = (resp_cnt == offset_width'(words_per_block - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= fill_idle;
            block_addr <= '0;
            issue_cnt  <= '0;
            resp_cnt   <= '0;
        end else begin
            case (state)
                fill_idle: begin
                    if (miss) begin
                        state      <= fill_issue;  // fetch starts on the next cycle
                        block_addr <= cpu_addr[addr_width-1 -: blk_width];
                        issue_cnt  <= '0;
                        resp_cnt   <= '0;
                    end
                end
                fill_issue: begin
                    issue_cnt <= issue_cnt + 1'b1;  // memory takes one read per cycle
                    if (last_issue) begin
                        state <= fill_drain;
                    end
                end
                fill_drain: begin
                    if (mem.read_valid && last_resp) begin
                        state <= fill_idle;  // tag is written at this same edge
                    end
                end
                default: state <= fill_idle;
            endcase
            // responses overlap the issue phase, so they are counted in any fill state
            if (state != fill_idle && mem.read_valid) begin
                resp_cnt <= resp_cnt + 1'b1;
            end
        end
    end

    // held through the whole fill, then the retried access hits once idle again
    assign stall = (state != fill_idle) || miss;

    // each returning word lands at the offset given by the response count
    assign fill_write  = (state != fill_idle) && mem.read_valid;
    assign fill_offset = resp_cnt;
    assign tag_write   = (state == fill_drain) && mem.read_valid && last_resp;

    // a write is accepted only on a hit while idle, and goes straight to memory
    assign cpu_write_hit = (state == fill_idle) && cpu_req && hit && (cpu_op == op_write);

    // memory port is shared by the fill reads and the write-through traffic
    assign mem.read_req   = (state == fill_issue);
    assign mem.write_req  = cpu_write_hit;
    assign mem.address    = (state == fill_issue) ? {block_addr, issue_cnt, 1'b0} : cpu_addr;
    assign mem.write_data = cpu_wdata;

endmodule

//--- design/cache_pkg.sv
// Cache geometry and shared types
package cache_pkg;

    // processor and memory addresses are byte addresses of this width
    localparam int addr_width      = 16;
    localparam int data_width      = 16;   // one word moves per memory transfer

    // address split is tag | index | word offset | byte bit
    localparam int tag_width       = 5;    // address bits 15 to 11
    localparam int index_width     = 7;    // address bits 10 to 4
    localparam int offset_width    = 3;    // address bits 3 to 1, bit 0 is the byte bit

    localparam int num_sets        = 128;  // direct mapped, one block per set
    localparam int words_per_block = 8;    // 16 byte block of 16 bit words

    // backing memory characteristics
    localparam int mem_latency     = 4;    // cycles from a taken read to read_valid
    localparam int mem_words       = 32768; // 64 KB seen as 16 bit words

    // fill controller states
    typedef enum logic [1:0] {
        fill_idle  = 2'd0,  // serving hits and write-through traffic
        fill_issue = 2'd1,  // sending the eight block reads back to back
        fill_drain = 2'd2   // all reads sent, waiting on the last responses
    } fill_state_t;

    // processor access type
    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } cpu_op_t;

endpackage

//--- design/cache_tag_array.sv
// Tag and valid storage
`timescale 1ns/1ps

module cache_tag_array (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [cache_pkg::addr_width-1:0] addr,
    input  logic                             tag_write,
    output logic                             hit
);
    import cache_pkg::*;

    logic [tag_width-1:0]   tags [num_sets];  // stored tag per set
    logic [num_sets-1:0]    valid;            // one valid bit per set
    logic [tag_width-1:0]   addr_tag;
    logic [index_width-1:0] addr_index;

    assign addr_tag   = addr[addr_width-1 -: tag_width];     // bits 15 to 11
    assign addr_index = addr[1 + offset_width +: index_width];  // bits 10 to 4

    // valid bits are the only state that reset has to clear
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= '0;
        end else if (tag_write) begin
            valid[addr_index] <= 1'b1;  // fill finished, block is now usable
        end
    end

    // a fill simply overwrites whatever block the set held before
    always_ff @(posedge clk) begin
        if (tag_write) begin
            tags[addr_index] <= addr_tag;
        end
    end

    // hit is combinational so stall can react in the same cycle
    assign hit = valid[addr_index] && (tags[addr_index] == addr_tag);

endmodule

//--- design/cache_top.sv
// Write-through cache top level
`timescale 1ns/1ps

module cache_top (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             cpu_req,
    input  cache_pkg::cpu_op_t               cpu_op,
    input  logic [cache_pkg::addr_width-1:0] cpu_addr,
    input  logic [cache_pkg::data_width-1:0] cpu_wdata,
    output logic [cache_pkg::data_width-1:0] cpu_rdata,
    output logic                             stall
);
    import cache_pkg::*;

    logic                    hit;            // tag match on the current address
    logic                    fill_write;     // returning fill word goes into the data array
    logic [offset_width-1:0] fill_offset;    // slot of that fill word in the block
    logic                    tag_write;      // last fill word arrived, block becomes valid
    logic                    cpu_write_hit;  // accepted write also updates the cached copy

    mem_bus_if mem_bus (
        .clk (clk)
    );

    cache_fill_fsm fsm0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .cpu_req       (cpu_req),
        .cpu_op        (cpu_op),
        .cpu_addr      (cpu_addr),
        .cpu_wdata     (cpu_wdata),
        .hit           (hit),
        .mem           (mem_bus.controller),
        .stall         (stall),
        .fill_write    (fill_write),
        .fill_offset   (fill_offset),
        .tag_write     (tag_write),
        .cpu_write_hit (cpu_write_hit)
    );

    cache_tag_array tags0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .addr      (cpu_addr),
        .tag_write (tag_write),
        .hit       (hit)
    );

    cache_data_array data0 (
        .clk           (clk),
        .addr          (cpu_addr),
        .fill_write    (fill_write),
        .fill_offset   (fill_offset),
        .fill_data     (mem_bus.read_data),  // fill words come straight off the bus
        .cpu_write_hit (cpu_write_hit),
        .cpu_wdata     (cpu_wdata),
        .rdata         (cpu_rdata)
    );

    mem_model mem0 (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (mem_bus.memory)
    );

endmodule

//--- design/mem_bus_if.sv
// Memory request and response bus
`timescale 1ns/1ps

interface mem_bus_if (
    input logic clk
);
    import cache_pkg::*;

    logic                  read_req;    // read request, always taken at the edge
    logic                  write_req;   // write request, memory updates at the edge
    logic [addr_width-1:0] address;     // byte address shared by reads and writes
    logic [data_width-1:0] write_data;  // word that goes along with write_req
    logic [data_width-1:0] read_data;   // returned word, good only with read_valid
    logic                  read_valid;  // one pulse per read, mem_latency cycles later

    // the cache controller side issues requests and takes responses
    modport controller (
        input  clk,
        output read_req, write_req, address, write_data,
        input  read_data, read_valid
    );

    // the memory side answers requests
    modport memory (
        input  clk,
        input  read_req, write_req, address, write_data,
        output read_data, read_valid
    );

endinterface

//--- design/mem_model.sv
// Pipelined backing memory model
`timescale 1ns/1ps

module mem_model (
    input  logic      clk,
    input  logic      rst_n,
    mem_bus_if.memory bus
);
    import cache_pkg::*;

    localparam int word_bits = $clog2(mem_words);  // 15 bits of word address

    logic [data_width-1:0] mem [mem_words];
    logic [mem_latency-1:0] pipe_valid;               // one bit per read in flight
    logic [data_width-1:0]  pipe_data [mem_latency];  // word travelling with each bit
    logic [word_bits-1:0]   word_addr;

    assign word_addr = bus.address[addr_width-1 -: word_bits];  // byte bit ignored

    // memory content starts at zero so every expected value is known
    initial begin
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = '0;
        end
    end

    // writes land at the edge they are requested
    always_ff @(posedge clk) begin
        if (bus.write_req) begin
            mem[word_addr] <= bus.write_data;
        end
    end

    // valid bits are control, cleared so nothing stale returns after reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pipe_valid <= '0;
        end else begin
            pipe_valid <= {pipe_valid[mem_latency-2:0], bus.read_req};
        end
    end

    // data is sampled when the read is taken and then shifted along
    always_ff @(posedge clk) begin
        pipe_data[0] <= mem[word_addr];
        for (int s = 1; s < mem_latency; s++) begin
            pipe_data[s] <= pipe_data[s-1];
        end
    end

    // the last stage is visible mem_latency cycles after the request cycle
    assign bus.read_valid = pipe_valid[mem_latency-1];
    assign bus.read_data  = pipe_data[mem_latency-1];

endmodule
